// File: Bender.yml
package:
  name: husky_ctrl

sources:
  - files:
      - source/husky_pkg.sv
      - source/host_bus_fsm.sv
      - source/capture_ctrl_regs.sv
      - source/capture_fifo.sv
      - source/error_flash_timer.sv
      - source/husky_ctrl_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/husky_ctrl_tb.sv

// File: flist.f
source/husky_pkg.sv
source/host_bus_fsm.sv
source/capture_ctrl_regs.sv
source/capture_fifo.sv
source/error_flash_timer.sv
source/husky_ctrl_top.sv
+incdir+tests
tests/husky_ctrl_tb.sv

// File: source/capture_ctrl_regs.sv
`default_nettype none

module capture_ctrl_regs import husky_pkg::*; (
   input  wire             clk_usb_buf,
   input  wire             rst_i,
   input  wire reg_bus_t   bus_i,
   output logic [7:0]      rdata_o,
   output capture_ctrl_t   ctrl_o,
   input  wire             sam_mosi_i,
   input  wire             sam_spck_i,
   input  wire             target_miso_i,
   output target_pins_t    target_o,
   output logic            sam_miso_o,
   output logic            sam_miso_oe_o,
   output logic            led_armed_o
);

   logic       arm_q;
   fifo_src_e  src_q;
   logic       clear_q;
   logic       flush_q;
   logic       power_off_q;
   logic       avrprog_q;
   logic       nrst_oe_q;
   logic       nrst_q;
   logic       ctrl_wr;
   logic       tgt_wr;
   logic       drive_ok;

   assign ctrl_wr = bus_i.write && (bus_i.addr == ADDR_CTRL);
   assign tgt_wr  = bus_i.write && (bus_i.addr == ADDR_TARGET);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         arm_q   <= 1'b0;
         src_q   <= SRC_TRACE;
         clear_q <= 1'b0;
         flush_q <= 1'b0;
      end else begin
         clear_q <= ctrl_wr && bus_i.wdata[CTRL_CLEAR_BIT];   // One-cycle pulse
         flush_q <= ctrl_wr && bus_i.wdata[CTRL_FLUSH_BIT];
         if (ctrl_wr) begin
            arm_q <= bus_i.wdata[CTRL_ARM_BIT];
            src_q <= fifo_src_e'(bus_i.wdata[CTRL_SRC_BIT]);
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         power_off_q <= 1'b0;   // Target powered
         avrprog_q   <= 1'b0;
         nrst_oe_q   <= 1'b0;
         nrst_q      <= 1'b0;
      end else if (tgt_wr) begin
         power_off_q <= bus_i.wdata[TGT_POWER_OFF_BIT];
         avrprog_q   <= bus_i.wdata[TGT_AVRPROG_BIT];
         nrst_oe_q   <= bus_i.wdata[TGT_NRST_OE_BIT];
         nrst_q      <= bus_i.wdata[TGT_NRST_BIT];
      end
   end

   // Clear and flush are not stored, so they read as zero
   always_comb begin
      rdata_o = '0;
      if (bus_i.addr == ADDR_CTRL) begin
         rdata_o[CTRL_ARM_BIT] = arm_q;
         rdata_o[CTRL_SRC_BIT] = src_q;
      end else if (bus_i.addr == ADDR_TARGET) begin
         rdata_o[TGT_POWER_OFF_BIT] = power_off_q;
         rdata_o[TGT_AVRPROG_BIT]   = avrprog_q;
         rdata_o[TGT_NRST_OE_BIT]   = nrst_oe_q;
         rdata_o[TGT_NRST_BIT]      = nrst_q;
      end
   end

   // Unpowered target gets no driven pins at all
   assign drive_ok = !power_off_q;

   always_comb begin
      target_o.power_on = !power_off_q;
      target_o.mosi     = sam_mosi_i;
      target_o.mosi_oe  = drive_ok && avrprog_q;
      target_o.sck      = sam_spck_i;
      target_o.sck_oe   = drive_ok && avrprog_q;
      target_o.nrst     = nrst_q;
      target_o.nrst_oe  = drive_ok && !avrprog_q && nrst_oe_q;   // Register control only
   end

   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = drive_ok && avrprog_q;
   assign led_armed_o   = arm_q;

   assign ctrl_o = '{arm: arm_q, src: src_q, clear_errors: clear_q, flush: flush_q};

   a_pulses_single: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      (clear_q || flush_q) |=> !(clear_q || flush_q));

endmodule

`default_nettype wire

// File: source/capture_fifo.sv
`default_nettype none

module capture_fifo import husky_pkg::*; (
   input  wire                clk_usb_buf,
   input  wire                rst_i,
   input  wire reg_bus_t      bus_i,
   input  wire capture_ctrl_t ctrl_i,
   input  wire sample_t       trace_sample_i,
   input  wire sample_t       la_sample_i,
   output logic [7:0]         rdata_o,
   output logic               error_o
);

   sample_t                  sample_in;
   logic [SAMPLE_W-1:0]      mem_q [FIFO_DEPTH];
   logic [FIFO_COUNT_W-2:0]  wr_ptr_q;
   logic [FIFO_COUNT_W-2:0]  rd_ptr_q;
   logic [FIFO_COUNT_W-1:0]  count_q;
   logic                     hi_phase_q;   // Next data read returns high byte
   logic                     overflow_q;
   logic                     underflow_q;
   logic                     full;
   logic                     empty;
   logic                     push;
   logic                     drop;
   logic                     data_rd;
   logic                     pop;
   logic [SAMPLE_W-1:0]      head;

   assign sample_in = (ctrl_i.src == SRC_LA) ? la_sample_i : trace_sample_i;

   assign full  = (count_q == FIFO_COUNT_W'(FIFO_DEPTH));
   assign empty = (count_q == '0);

   // No back-pressure, a full FIFO loses the sample
   assign push = sample_in.valid && ctrl_i.arm && !full;
   assign drop = sample_in.valid && ctrl_i.arm && full;

   assign data_rd = bus_i.read && (bus_i.addr == ADDR_FIFO_DATA);
   assign pop     = data_rd && hi_phase_q && !empty;
   assign head    = mem_q[rd_ptr_q];

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem_q[wr_ptr_q] <= sample_in.data;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i || ctrl_i.flush) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         hi_phase_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
         if (data_rd && !empty) begin
            hi_phase_q <= !hi_phase_q;
         end
      end
   end

   // Sticky until the host writes clear
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i || ctrl_i.clear_errors) begin
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         if (drop) begin
            overflow_q <= 1'b1;
         end
         if (data_rd && empty) begin
            underflow_q <= 1'b1;
         end
      end
   end

   always_comb begin
      case (bus_i.addr)
         ADDR_STATUS:     rdata_o = {4'b0, underflow_q, overflow_q, full, empty};
         ADDR_FIFO_COUNT: rdata_o = {{(8-FIFO_COUNT_W){1'b0}}, count_q};
         ADDR_FIFO_DATA: begin
            if (empty) begin
               rdata_o = '0;
            end else begin
               rdata_o = hi_phase_q ? head[15:8] : head[7:0];
            end
         end
         default:         rdata_o = '0;
      endcase
   end

   assign error_o = overflow_q | underflow_q;

   a_count_bound: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      count_q <= FIFO_COUNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: source/error_flash_timer.sv
`default_nettype none

module error_flash_timer import husky_pkg::*; (
   input  wire   clk_usb_buf,
   input  wire   rst_i,
   input  wire   error_i,
   output logic  led_error_o
);

   logic [FLASH_CNT_W-1:0]  cnt_q;
   logic                    pattern_q;

   // Free-running, independent of the error flag
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         cnt_q     <= '0;
         pattern_q <= 1'b0;
      end else if (cnt_q == FLASH_CNT_W'(FLASH_HALF_PERIOD - 1)) begin
         cnt_q     <= '0;
         pattern_q <= !pattern_q;   // Half period done
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // LED dark unless some error is pending
   assign led_error_o = error_i && pattern_q;

endmodule

`default_nettype wire

// File: source/host_bus_fsm.sv
`default_nettype none

module host_bus_fsm import husky_pkg::*; (
   input  wire             clk_usb_buf,
   input  wire             rst_i,
   input  wire host_bus_t  host_i,
   input  wire [7:0]       usb_data_i,
   input  wire [7:0]       ctrl_rdata_i,
   input  wire [7:0]       fifo_rdata_i,
   output reg_bus_t        bus_o,
   output logic [7:0]      usb_data_o,
   output logic            usb_data_oe_o
);

   bus_state_e  state_q;
   logic [7:0]  addr_q;
   logic [7:0]  wdata_q;
   logic        write_q;
   logic        read_q;
   logic        wrn_q;
   logic        rdn_q;
   logic [7:0]  rdata_q;
   logic        write_start;
   logic        read_start;

   // Falling strobe while chip enable is low
   assign write_start = !host_i.cen_n && !host_i.wrn && wrn_q;
   assign read_start  = !host_i.cen_n && !host_i.rdn && rdn_q;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wrn_q <= 1'b1;
         rdn_q <= 1'b1;
      end else begin
         wrn_q <= host_i.wrn;
         rdn_q <= host_i.rdn;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         addr_q <= '0;
      end else if (!host_i.alen_n && !host_i.cen_n) begin
         addr_q <= host_i.addr;   // Latched on every ALE cycle
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (write_start) begin
         wdata_q <= usb_data_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state_q <= BUS_IDLE;
         write_q <= 1'b0;
         read_q  <= 1'b0;
      end else begin
         write_q <= 1'b0;
         read_q  <= 1'b0;
         case (state_q)
            BUS_IDLE: begin
               if (write_start) begin
                  state_q <= BUS_WRITE;
                  write_q <= 1'b1;
               end else if (read_start) begin
                  state_q <= BUS_READ_WAIT;
                  read_q  <= 1'b1;
               end
            end
            BUS_WRITE: begin
               if (host_i.wrn) begin
                  state_q <= BUS_IDLE;
               end
            end
            BUS_READ_WAIT: state_q <= BUS_READ_HOLD;   // Data captured here
            BUS_READ_HOLD: begin
               if (host_i.rdn) begin
                  state_q <= BUS_IDLE;
               end
            end
            default: state_q <= BUS_IDLE;
         endcase
      end
   end

   // Block replies merged once per read and held until rdn rises
   always_ff @(posedge clk_usb_buf) begin
      if (state_q == BUS_READ_WAIT) begin
         rdata_q <= ctrl_rdata_i | fifo_rdata_i;
      end
   end

   assign bus_o = '{addr: addr_q, wdata: wdata_q, write: write_q, read: read_q};
   assign usb_data_o    = rdata_q;
   assign usb_data_oe_o = (state_q == BUS_READ_HOLD) && !host_i.rdn;

   // Host never holds both strobes low while selected
   a_no_rw_overlap: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      !(!host_i.cen_n && !host_i.rdn && !host_i.wrn));

endmodule

`default_nettype wire

// File: source/husky_ctrl_top.sv
`default_nettype none

module husky_ctrl_top import husky_pkg::*; (
   input  wire             clk_usb_buf,
   input  wire             rst_i,
   input  wire host_bus_t  host_i,
   input  wire [7:0]       usb_data_i,
   output logic [7:0]      usb_data_o,
   output logic            usb_data_oe_o,
   input  wire sample_t    trace_sample_i,
   input  wire sample_t    la_sample_i,
   input  wire             sam_mosi_i,
   input  wire             sam_spck_i,
   input  wire             target_miso_i,
   output target_pins_t    target_o,
   output logic            sam_miso_o,
   output logic            sam_miso_oe_o,
   output logic            led_error_o,
   output logic            led_armed_o
);

   reg_bus_t       reg_bus;
   logic [7:0]     ctrl_rdata;
   logic [7:0]     fifo_rdata;
   capture_ctrl_t  capture_ctrl;
   logic           fifo_error;

   host_bus_fsm u_host_bus_fsm (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .host_i         (host_i),
      .usb_data_i     (usb_data_i),
      .ctrl_rdata_i   (ctrl_rdata),
      .fifo_rdata_i   (fifo_rdata),
      .bus_o          (reg_bus),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o)
   );

   capture_ctrl_regs u_capture_ctrl_regs (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .bus_i          (reg_bus),
      .rdata_o        (ctrl_rdata),
      .ctrl_o         (capture_ctrl),
      .sam_mosi_i     (sam_mosi_i),
      .sam_spck_i     (sam_spck_i),
      .target_miso_i  (target_miso_i),
      .target_o       (target_o),
      .sam_miso_o     (sam_miso_o),
      .sam_miso_oe_o  (sam_miso_oe_o),
      .led_armed_o    (led_armed_o)
   );

   // Shared by trace and LA streams
   capture_fifo u_capture_fifo (
      .clk_usb_buf     (clk_usb_buf),
      .rst_i           (rst_i),
      .bus_i           (reg_bus),
      .ctrl_i          (capture_ctrl),
      .trace_sample_i  (trace_sample_i),
      .la_sample_i     (la_sample_i),
      .rdata_o         (fifo_rdata),
      .error_o         (fifo_error)
   );

   error_flash_timer u_error_flash_timer (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .error_i      (fifo_error),
      .led_error_o  (led_error_o)
   );

endmodule

`default_nettype wire

// File: source/husky_pkg.sv
`default_nettype none

package husky_pkg;

   // Host register map
   localparam logic [7:0] ADDR_STATUS     = 8'h01; // Read only
   localparam logic [7:0] ADDR_CTRL       = 8'h02;
   localparam logic [7:0] ADDR_TARGET     = 8'h03;
   localparam logic [7:0] ADDR_FIFO_DATA  = 8'h04; // Read pops one byte
   localparam logic [7:0] ADDR_FIFO_COUNT = 8'h05; // In samples

   // Capture control bits, clear and flush self-clear
   localparam int CTRL_ARM_BIT   = 0;
   localparam int CTRL_SRC_BIT   = 1;
   localparam int CTRL_CLEAR_BIT = 2;
   localparam int CTRL_FLUSH_BIT = 3;

   // Target control bits
   localparam int TGT_POWER_OFF_BIT = 0;
   localparam int TGT_AVRPROG_BIT   = 1;
   localparam int TGT_NRST_OE_BIT   = 2;
   localparam int TGT_NRST_BIT      = 3;

   localparam int FIFO_DEPTH   = 32;
   localparam int FIFO_COUNT_W = 6;
   localparam int SAMPLE_W     = 16;

   // Short on purpose so the LED visibly blinks in simulation
   localparam int FLASH_HALF_PERIOD = 8;
   localparam int FLASH_CNT_W       = 3;

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_WRITE,
      BUS_READ_WAIT,
      BUS_READ_HOLD
   } bus_state_e;

   typedef enum logic {
      SRC_TRACE = 1'b0,
      SRC_LA    = 1'b1
   } fifo_src_e;

   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] wdata;
      logic       write;   // One-cycle pulse
      logic       read;    // One-cycle pulse
   } reg_bus_t;

   typedef struct packed {
      logic                valid;
      logic [SAMPLE_W-1:0] data;
   } sample_t;

   typedef struct packed {
      logic      arm;
      fifo_src_e src;
      logic      clear_errors;
      logic      flush;
   } capture_ctrl_t;

   typedef struct packed {
      logic power_on;
      logic nrst_oe;
      logic nrst;
      logic mosi_oe;
      logic mosi;
      logic sck_oe;
      logic sck;
   } target_pins_t;

   typedef struct packed {
      logic [7:0] addr;
      logic       cen_n;
      logic       alen_n;
      logic       rdn;
      logic       wrn;
   } host_bus_t;

endpackage

`default_nettype wire

// File: tests/husky_tb_tasks.svh
// Advance to the drive point just after the next rising edge
task automatic wait_cycle();
   @(posedge clk_usb_buf);
   #DRIVE_DELAY;
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
   end
endtask

// Address latch cycle, then wrn low 4 cycles and high 2
task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
   host.addr   = addr;
   host.cen_n  = 1'b0;
   host.alen_n = 1'b0;
   usb_data_i  = data;
   wait_cycle();
   host.alen_n = 1'b1;
   host.wrn    = 1'b0;
   repeat (4) wait_cycle();
   host.wrn = 1'b1;
   repeat (2) wait_cycle();
   host.cen_n = 1'b1;
endtask

task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
   host.addr   = addr;
   host.cen_n  = 1'b0;
   host.alen_n = 1'b0;
   wait_cycle();
   host.alen_n = 1'b1;
   host.rdn    = 1'b0;
   repeat (3) wait_cycle();   // Data registered by now
   data = usb_data_o;
   check("usb_data_oe_o", usb_data_oe_o, 1'b1);
   wait_cycle();
   host.rdn = 1'b1;
   repeat (2) wait_cycle();
   host.cen_n = 1'b1;
endtask

function automatic logic [15:0] rand_word();
   int unsigned r;
   r = $urandom;
   return r[15:0];
endfunction

// One valid sample on each stream for a single cycle
task automatic push_sample(input logic [15:0] trace_data, input logic [15:0] la_data);
   trace_sample = '{valid: 1'b1, data: trace_data};
   la_sample    = '{valid: 1'b1, data: la_data};
   wait_cycle();
   trace_sample.valid = 1'b0;
   la_sample.valid    = 1'b0;
endtask

// File: tests/husky_ctrl_tb.sv
`default_nettype none

module husky_ctrl_tb import husky_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;
   // Watchdog budget from 7-cycle bus accesses plus sample pushes and LED watching
   localparam int BUS_ACCESSES   = 130;
   localparam int ACCESS_CYCLES  = 7;
   localparam int OTHER_CYCLES   = 250;
   localparam int TIMEOUT_CYCLES = 2 * (BUS_ACCESSES * ACCESS_CYCLES + OTHER_CYCLES);

   localparam logic [7:0] ST_EMPTY = 8'h01;   // Status register layout
   localparam logic [7:0] ST_FULL  = 8'h02;
   localparam logic [7:0] ST_OVF   = 8'h04;
   localparam logic [7:0] ST_UDF   = 8'h08;

   logic          clk_usb_buf;
   logic          rst_i;
   host_bus_t     host;
   logic [7:0]    usb_data_i;
   logic [7:0]    usb_data_o;
   logic          usb_data_oe_o;
   sample_t       trace_sample;
   sample_t       la_sample;
   logic          sam_mosi;
   logic          sam_spck;
   logic          target_miso;
   target_pins_t  target_pins;
   logic          sam_miso;
   logic          sam_miso_oe;
   logic          led_error;
   logic          led_armed;
   int            check_count;
   int            error_count;
   int            seed;
   logic [15:0]   expected_q[$];   // Samples still due from the FIFO

   husky_ctrl_top uut (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .host_i         (host),
      .usb_data_i     (usb_data_i),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o),
      .trace_sample_i (trace_sample),
      .la_sample_i    (la_sample),
      .sam_mosi_i     (sam_mosi),
      .sam_spck_i     (sam_spck),
      .target_miso_i  (target_miso),
      .target_o       (target_pins),
      .sam_miso_o     (sam_miso),
      .sam_miso_oe_o  (sam_miso_oe),
      .led_error_o    (led_error),
      .led_armed_o    (led_armed)
   );

   initial clk_usb_buf = 1'b0;
   always #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;

   `include "husky_tb_tasks.svh"

   function automatic logic [7:0] ctrl_word(input logic arm, input logic src,
                                            input logic clr, input logic flush);
      logic [7:0] w;
      w = '0;
      w[CTRL_ARM_BIT]   = arm;
      w[CTRL_SRC_BIT]   = src;
      w[CTRL_CLEAR_BIT] = clr;
      w[CTRL_FLUSH_BIT] = flush;
      return w;
   endfunction

   function automatic logic [7:0] tgt_word(input logic power_off, input logic avrprog,
                                           input logic nrst_oe, input logic nrst);
      logic [7:0] w;
      w = '0;
      w[TGT_POWER_OFF_BIT] = power_off;
      w[TGT_AVRPROG_BIT]   = avrprog;
      w[TGT_NRST_OE_BIT]   = nrst_oe;
      w[TGT_NRST_BIT]      = nrst;
      return w;
   endfunction

   task automatic report_test(input string name, input int errors_before);
      $display("test %s done, %0d errors", name, error_count - errors_before);
   endtask

   // Low byte then high byte for each expected sample
   task automatic drain_expected();
      logic [7:0]  lo;
      logic [7:0]  hi;
      logic [15:0] exp;
      while (expected_q.size() > 0) begin
         exp = expected_q.pop_front();
         bus_read(ADDR_FIFO_DATA, lo);
         bus_read(ADDR_FIFO_DATA, hi);
         check("fifo data low byte", lo, exp[7:0]);
         check("fifo data high byte", hi, exp[15:8]);
      end
   endtask

   task automatic reset_readback();
      logic [7:0] rd;
      int         errs;
      errs = error_count;
      check("usb_data_oe_o", usb_data_oe_o, 1'b0);
      check("led_armed_o", led_armed, 1'b0);
      check("led_error_o", led_error, 1'b0);
      check("target power_on", target_pins.power_on, 1'b1);
      check("target nrst_oe", target_pins.nrst_oe, 1'b0);
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY);
      bus_read(ADDR_FIFO_COUNT, rd);
      check("fifo count", rd, 8'd0);
      check("usb_data_oe_o", usb_data_oe_o, 1'b0);   // Released after the read
      bus_write(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, 1'b1));
      bus_read(ADDR_CTRL, rd);
      check("ctrl readback", rd, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
      bus_write(ADDR_TARGET, tgt_word(1'b0, 1'b1, 1'b0, 1'b1));
      bus_read(ADDR_TARGET, rd);
      check("target readback", rd, tgt_word(1'b0, 1'b1, 1'b0, 1'b1));
      bus_write(ADDR_TARGET, 8'h00);
      bus_write(ADDR_CTRL, 8'h00);
      report_test("reset_readback", errs);
   endtask

   task automatic capture_by_source();
      logic [7:0]  rd;
      logic [15:0] tr;
      logic [15:0] la;
      logic        src;
      int          errs;
      errs = error_count;
      for (int s = 0; s < 2; s++) begin
         src = (s == 0) ? SRC_LA : SRC_TRACE;
         bus_write(ADDR_CTRL, ctrl_word(1'b0, src, 1'b0, 1'b0));
         repeat (2) push_sample(rand_word(), rand_word());   // Dropped while disarmed
         bus_write(ADDR_CTRL, ctrl_word(1'b1, src, 1'b0, 1'b0));
         repeat (5) begin
            tr = rand_word();
            la = rand_word();
            expected_q.push_back((src == SRC_LA) ? la : tr);
            push_sample(tr, la);
         end
         bus_write(ADDR_CTRL, ctrl_word(1'b0, src, 1'b0, 1'b0));
         bus_read(ADDR_FIFO_COUNT, rd);
         check("fifo count", rd, 8'd5);
         drain_expected();
      end
      bus_read(ADDR_FIFO_COUNT, rd);
      check("fifo count", rd, 8'd0);
      report_test("capture_by_source", errs);
   endtask

   task automatic overflow_underflow();
      logic [7:0]  rd;
      logic [15:0] la;
      int          errs;
      errs = error_count;
      bus_write(ADDR_CTRL, ctrl_word(1'b1, SRC_LA, 1'b0, 1'b0));
      for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
         la = rand_word();
         if (i < FIFO_DEPTH) begin
            expected_q.push_back(la);
         end
         push_sample(rand_word(), la);
      end
      bus_write(ADDR_CTRL, 8'h00);
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_FULL | ST_OVF);
      drain_expected();
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY | ST_OVF);
      bus_read(ADDR_FIFO_DATA, rd);
      check("fifo data when empty", rd, 8'h00);
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY | ST_OVF | ST_UDF);
      bus_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY);
      report_test("overflow_underflow", errs);
   endtask

   task automatic flush_fifo();
      logic [7:0] rd;
      int         errs;
      errs = error_count;
      bus_write(ADDR_CTRL, ctrl_word(1'b1, SRC_TRACE, 1'b0, 1'b0));
      repeat (3) push_sample(rand_word(), rand_word());
      bus_write(ADDR_CTRL, 8'h00);
      bus_read(ADDR_FIFO_COUNT, rd);
      check("fifo count", rd, 8'd3);
      bus_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
      bus_read(ADDR_FIFO_COUNT, rd);
      check("fifo count", rd, 8'd0);
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY);
      report_test("flush_fifo", errs);
   endtask

   task automatic target_pin_modes();
      int errs;
      errs = error_count;
      // Power off wins over every other bit
      bus_write(ADDR_TARGET, tgt_word(1'b1, 1'b1, 1'b1, 1'b0));
      check("target power_on", target_pins.power_on, 1'b0);
      check("target mosi_oe", target_pins.mosi_oe, 1'b0);
      check("target sck_oe", target_pins.sck_oe, 1'b0);
      check("target nrst_oe", target_pins.nrst_oe, 1'b0);
      check("sam_miso_oe_o", sam_miso_oe, 1'b0);
      // Avrprog overrides the nrst_oe bit
      bus_write(ADDR_TARGET, tgt_word(1'b0, 1'b1, 1'b1, 1'b0));
      for (int p = 0; p < 4; p++) begin
         sam_mosi    = p[0];
         sam_spck    = p[1];
         target_miso = !p[0];
         wait_cycle();
         check("target mosi", target_pins.mosi, p[0]);
         check("target sck", target_pins.sck, p[1]);
         check("sam_miso_o", sam_miso, !p[0]);
      end
      check("target power_on", target_pins.power_on, 1'b1);
      check("target mosi_oe", target_pins.mosi_oe, 1'b1);
      check("target sck_oe", target_pins.sck_oe, 1'b1);
      check("sam_miso_oe_o", sam_miso_oe, 1'b1);
      check("target nrst_oe", target_pins.nrst_oe, 1'b0);
      bus_write(ADDR_TARGET, tgt_word(1'b0, 1'b0, 1'b1, 1'b1));
      check("target nrst_oe", target_pins.nrst_oe, 1'b1);
      check("target nrst", target_pins.nrst, 1'b1);
      check("target mosi_oe", target_pins.mosi_oe, 1'b0);
      check("sam_miso_oe_o", sam_miso_oe, 1'b0);
      bus_write(ADDR_TARGET, tgt_word(1'b0, 1'b0, 1'b1, 1'b0));
      check("target nrst", target_pins.nrst, 1'b0);
      bus_write(ADDR_TARGET, 8'h00);
      check("target nrst_oe", target_pins.nrst_oe, 1'b0);
      report_test("target_pin_modes", errs);
   endtask

   task automatic error_led_flash();
      logic [7:0] rd;
      logic       prev;
      int         errs;
      int         highs;
      int         toggles;
      int         run;
      int         max_run;
      errs  = error_count;
      highs = 0;
      repeat (40) begin
         wait_cycle();
         highs += led_error;
      end
      check("led_error_o high cycles", highs, 0);
      bus_write(ADDR_CTRL, ctrl_word(1'b1, SRC_TRACE, 1'b0, 1'b0));
      check("led_armed_o", led_armed, 1'b1);
      repeat (FIFO_DEPTH + 1) push_sample(rand_word(), rand_word());   // Forces overflow
      bus_write(ADDR_CTRL, 8'h00);
      check("led_armed_o", led_armed, 1'b0);
      toggles = 0;
      run     = 1;
      max_run = 1;
      prev    = led_error;
      repeat (40) begin
         wait_cycle();
         if (led_error != prev) begin
            toggles++;
            run = 1;
         end else begin
            run++;
         end
         if (run > max_run) begin
            max_run = run;
         end
         prev = led_error;
      end
      if (toggles < 2) begin
         error_count++;
         $display("LED toggled only %0d times while overflow was set", toggles);
      end
      if (max_run > FLASH_HALF_PERIOD) begin
         error_count++;
         $display("LED held one value for %0d cycles, longer than a half period", max_run);
      end
      bus_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b1));   // Clear errors and flush
      highs = 0;
      repeat (20) begin
         wait_cycle();
         highs += led_error;
      end
      check("led_error_o high cycles", highs, 0);
      bus_read(ADDR_STATUS, rd);
      check("status", rd, ST_EMPTY);
      report_test("error_led_flash", errs);
   endtask

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Checks failed");
      $finish;
   end

   initial begin
      check_count  = 0;
      error_count  = 0;
      seed         = 56143;
      void'($urandom(seed));
      host         = '{addr: 8'h00, cen_n: 1'b1, alen_n: 1'b1, rdn: 1'b1, wrn: 1'b1};
      usb_data_i   = 8'h00;
      trace_sample = '0;
      la_sample    = '0;
      sam_mosi     = 1'b0;
      sam_spck     = 1'b0;
      target_miso  = 1'b0;
      rst_i        = 1'b1;
      repeat (4) @(posedge clk_usb_buf);
      #DRIVE_DELAY;
      rst_i = 1'b0;
      reset_readback();
      capture_by_source();
      overflow_underflow();
      flush_fifo();
      target_pin_modes();
      error_led_flash();
      $display("%0d checks run, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
